// ==== rtl/approx_compressor_cell.sv ====
// Approximate two-row compressor where the true sum is p_o plus q_o at equal weight
`timescale 1ns/1ps

module approx_compressor_cell
    import vpu_pkg::*;
#(
    parameter int WIDTH      = LANE_W,
    parameter int SHIFT_BITS = 1
)
(
    input  logic [WIDTH-1:0]            row1_i,
    input  logic [WIDTH-1:0]            row2_i,
    output logic [WIDTH+SHIFT_BITS-1:0] p_o,
    output logic [WIDTH+SHIFT_BITS-1:0] q_o
);

    localparam int OUT_W = WIDTH + SHIFT_BITS;

    logic [OUT_W-1:0] row2_shifted;

    assign row2_shifted = OUT_W'(row2_i) << SHIFT_BITS;

    // Low columns hold row 1 alone
    assign p_o[SHIFT_BITS-1:0] = row1_i[SHIFT_BITS-1:0];
    assign q_o[SHIFT_BITS-1:0] = '0;

    // Overlap
    assign p_o[WIDTH-1:SHIFT_BITS] = row1_i[WIDTH-1:SHIFT_BITS] | row2_shifted[WIDTH-1:SHIFT_BITS];
    assign q_o[WIDTH-1:SHIFT_BITS] = row1_i[WIDTH-1:SHIFT_BITS] & row2_shifted[WIDTH-1:SHIFT_BITS];

    assign p_o[OUT_W-1:WIDTH] = row2_shifted[OUT_W-1:WIDTH];  // Row 2 alone
    assign q_o[OUT_W-1:WIDTH] = '0;

endmodule

// ==== rtl/approx_multiplier.sv ====
// Approximate unsigned 8x8 multiplier that is exact only when the multiplier has at most one bit set
`timescale 1ns/1ps

module approx_multiplier
    import vpu_pkg::*;
(
    input  lane_t    multiplicand_i,
    input  lane_t    multiplier_i,
    output product_t product_o
);

    localparam int MID_LO   = 4;   // Correction row overlap starts
    localparam int MID_HI   = 10;  // and ends here
    localparam int ORED_HI  = 4;   // Top column of the OR-ed final stage
    localparam int RIPPLE_LO = ORED_HI + 1;

    lane_t             pp [LANE_W];
    tree_out_t         tree;
    logic [TREE_W-1:0] p7;
    logic [TREE_W-1:0] q7;
    logic [TREE_W-1:0] v1;
    logic [TREE_W-1:0] v2;
    logic [TREE_W-1:0] sum_s;
    logic [TREE_W-1:2] carry_s;  // Columns 0 and 1 never carry

    // Partial products
    for (genvar k = 0; k < LANE_W; k++)
    begin : g_pp
        assign pp[k] = multiplicand_i & {LANE_W{multiplier_i[k]}};
    end

    compressor_tree u_tree (
        .pp_i   (pp),
        .tree_o (tree)
    );

    assign p7 = tree.compressed_row;
    assign q7 = tree.correction_row;
    assign v1 = tree.overflow_v1;
    assign v2 = tree.overflow_v2;

    // Stage 3 column sums
    always_comb
    begin
        logic a;
        logic b;
        logic c;

        sum_s[0]   = p7[0];
        sum_s[1]   = p7[1] ^ v1[1];  // Half adder
        carry_s[2] = p7[1] & v1[1];

        for (int col = 2; col <= 12; col++)
        begin
            a = p7[col];
            if (col >= MID_LO && col <= MID_HI)
            begin
                b = q7[col];
                c = v1[col] | v2[col];  // Both overflow vectors folded
            end
            else
            begin
                b = v1[col];
                c = v2[col];
            end
            sum_s[col]     = a ^ b ^ c;
            carry_s[col+1] = (a & b) | (a & c) | (b & c);
        end

        sum_s[13]   = p7[13] ^ v1[13];
        carry_s[14] = p7[13] & v1[13];
        sum_s[14]   = p7[14];
    end

    // Stage 4 final add
    always_comb
    begin
        logic [TREE_W:RIPPLE_LO] rc;

        product_o[1:0]       = sum_s[1:0];
        product_o[ORED_HI:2] = sum_s[ORED_HI:2] | carry_s[ORED_HI:2];  // Carries dropped

        rc[RIPPLE_LO] = 1'b0;
        for (int col = RIPPLE_LO; col < TREE_W; col++)
        begin
            product_o[col] = sum_s[col] ^ carry_s[col] ^ rc[col];
            rc[col+1]      = (sum_s[col] & carry_s[col]) | (rc[col] & (sum_s[col] ^ carry_s[col]));
        end
        product_o[TREE_W] = rc[TREE_W];
    end

endmodule

// ==== rtl/compressor_tree.sv ====
// Row and column layout holds only for LANE_W of 8 where the final row is TREE_W bits
`timescale 1ns/1ps

module compressor_tree
    import vpu_pkg::*;
(
    input  lane_t     pp_i [LANE_W],
    output tree_out_t tree_o
);

    localparam int S1_W = LANE_W + 1;  // Rows after first pairing
    localparam int S2_W = S1_W + 2;    // Rows after second pairing

    logic [S1_W-1:0]   p1 [4];
    logic [S1_W-1:0]   q1 [4];
    logic [S2_W-1:0]   p2 [2];
    logic [S2_W-1:0]   q2 [2];
    logic [TREE_W-1:0] p3;
    logic [TREE_W-1:0] q3;

    // Eight rows to four, pairs one column apart
    for (genvar k = 0; k < 4; k++)
    begin : g_stage1
        approx_compressor_cell #(
            .WIDTH      (LANE_W),
            .SHIFT_BITS (1)
        ) u_cell (
            .row1_i (pp_i[2*k]),
            .row2_i (pp_i[2*k+1]),
            .p_o    (p1[k]),
            .q_o    (q1[k])
        );
    end

    // Four rows to two, pairs two columns apart
    for (genvar k = 0; k < 2; k++)
    begin : g_stage2
        approx_compressor_cell #(
            .WIDTH      (S1_W),
            .SHIFT_BITS (2)
        ) u_cell (
            .row1_i (p1[2*k]),
            .row2_i (p1[2*k+1]),
            .p_o    (p2[k]),
            .q_o    (q2[k])
        );
    end

    approx_compressor_cell #(
        .WIDTH      (S2_W),
        .SHIFT_BITS (4)
    ) u_final_cell (
        .row1_i (p2[0]),
        .row2_i (p2[1]),
        .p_o    (p3),
        .q_o    (q3)
    );

    // AND terms of each stage squashed into one vector per stage
    always_comb
    begin
        logic [TREE_W-1:0] v1;
        logic [TREE_W-1:0] v2;

        v1 = '0;
        for (int k = 0; k < 4; k++)
        begin
            v1 = v1 | (TREE_W'(q1[k]) << (2*k));  // Stage 1 pair k sits at column 2k
        end

        v2 = '0;
        for (int k = 0; k < 2; k++)
        begin
            v2 = v2 | (TREE_W'(q2[k]) << (4*k));
        end

        tree_o.compressed_row = p3;
        tree_o.correction_row = q3;
        tree_o.overflow_v1    = v1;
        tree_o.overflow_v2    = v2;
    end

endmodule

// ==== rtl/lane_cla_adder.sv ====
// Combinational WIDTH-bit adder with carry-in and no carry-out
`timescale 1ns/1ps

module lane_cla_adder
    import vpu_pkg::*;
#(
    parameter int WIDTH = LANE_W
)
(
    input  logic [WIDTH-1:0] a_i,
    input  logic [WIDTH-1:0] b_i,
    input  logic             carry_i,
    output logic [WIDTH-1:0] sum_o
);

    logic [WIDTH-1:0] gen;    // Generate terms
    logic [WIDTH-1:0] prop;   // Propagate terms
    logic [WIDTH-1:0] carry;  // Carry into each bit

    assign gen  = a_i & b_i;
    assign prop = a_i | b_i;

    assign carry[0] = carry_i;

    // Lookahead terms chained bit by bit
    for (genvar i = 1; i < WIDTH; i++)
    begin : g_carry
        assign carry[i] = gen[i-1] | (prop[i-1] & carry[i-1]);
    end

    // Sum bits
    assign sum_o = a_i ^ b_i ^ carry;

endmodule

// ==== rtl/vector_processing_unit.sv ====
// Combinational four-lane SIMD unit and the dot product uses the approximate lane multipliers
`timescale 1ns/1ps

module vector_processing_unit
    import vpu_pkg::*;
(
    input  vpu_instr_t instr_i,
    input  vec_word_t  operand_a_i,
    input  vec_word_t  operand_b_i,
    output vec_word_t  result_o
);

    vpu_op_e   op;
    logic      sub_sel;
    lane_t     lane_a    [NUM_LANES];
    lane_t     lane_b    [NUM_LANES];
    lane_t     adder_b   [NUM_LANES];  // b after steering
    lane_t     lane_sum  [NUM_LANES];
    product_t  lane_prod [NUM_LANES];
    vec_word_t lane_word;
    vec_word_t dot_sum;

    vpu_decoder u_decoder (
        .instr_i (instr_i),
        .op_o    (op)
    );

    // Subtract as a plus inverted b plus one
    assign sub_sel = (op == OP_SUB);

    for (genvar k = 0; k < NUM_LANES; k++)
    begin : g_lane
        assign lane_a[k]  = operand_a_i[k*LANE_W +: LANE_W];
        assign lane_b[k]  = operand_b_i[k*LANE_W +: LANE_W];
        assign adder_b[k] = sub_sel ? ~lane_b[k] : lane_b[k];

        lane_cla_adder #(
            .WIDTH (LANE_W)
        ) u_adder (
            .a_i     (lane_a[k]),
            .b_i     (adder_b[k]),
            .carry_i (sub_sel),
            .sum_o   (lane_sum[k])
        );

        approx_multiplier u_mult (
            .multiplicand_i (lane_a[k]),
            .multiplier_i   (lane_b[k]),
            .product_o      (lane_prod[k])
        );
    end

    // Pack lane sums and accumulate the products
    always_comb
    begin
        lane_word = '0;
        dot_sum   = '0;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            lane_word[k*LANE_W +: LANE_W] = lane_sum[k];
            dot_sum = dot_sum + vec_word_t'(lane_prod[k]);  // Zero-extended
        end
    end

    always_comb
    begin
        case (op)
            OP_DOT:
                result_o = dot_sum;
            OP_CROSS:
                result_o = operand_a_i;  // Pass-through
            default:
                result_o = lane_word;    // Add and subtract
        endcase
    end

endmodule

// ==== rtl/vpu_decoder.sv ====
// Purely combinational and any word outside the four vector encodings decodes as add
`timescale 1ns/1ps

module vpu_decoder
    import vpu_pkg::*;
(
    input  vpu_instr_t instr_i,
    output vpu_op_e    op_o
);

    // Whole 17-bit word must match, so a stray funct7 or opcode falls to add
    always_comb
    begin
        case (instr_i)
            {F7_VECTOR, F3_VADD, OPC_OP_V}:
                op_o = OP_ADD;
            {F7_VECTOR, F3_VSUB, OPC_OP_V}:
                op_o = OP_SUB;
            {F7_VECTOR, F3_VDOT, OPC_OP_V}:
                op_o = OP_DOT;
            {F7_VECTOR, F3_VCROSS, OPC_OP_V}:
                op_o = OP_CROSS;
            default:
                op_o = OP_ADD;  // VSMUL lands here too
        endcase
    end

endmodule

// ==== rtl/vpu_pkg.sv ====
// Lane geometry is fixed at four 8-bit lanes and only funct7, funct3 and opcode are decoded
package vpu_pkg;

    localparam int LANE_W    = 8;
    localparam int NUM_LANES = 4;
    localparam int TREE_W    = 2*LANE_W - 1;  // Widest compressor row

    typedef logic [LANE_W-1:0]           lane_t;
    typedef logic [NUM_LANES*LANE_W-1:0] vec_word_t;
    typedef logic [2*LANE_W-1:0]         product_t;

    // R-type fields that select a vector operation
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam opcode_t OPC_OP_V  = 7'b11_110_11;  // Custom vector major opcode
    localparam funct7_t F7_VECTOR = 7'b111_0000;   // Vector arithmetic group

    localparam funct3_t F3_VADD   = 3'b000;
    localparam funct3_t F3_VSUB   = 3'b001;
    localparam funct3_t F3_VDOT   = 3'b010;
    localparam funct3_t F3_VCROSS = 3'b011;
    localparam funct3_t F3_VSMUL  = 3'b100;  // Not decoded, behaves as VADD

    // Instruction bits that matter, MSB first as in the encoding
    typedef struct packed {
        funct7_t funct7;
        funct3_t funct3;
        opcode_t opcode;
    } vpu_instr_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_DOT,
        OP_CROSS
    } vpu_op_e;

    // Compressor tree outputs, all aligned to product column 0
    typedef struct packed {
        logic [TREE_W-1:0] compressed_row;  // Final P
        logic [TREE_W-1:0] correction_row;  // Final Q
        logic [TREE_W-1:0] overflow_v1;     // AND terms of the 8-row stage
        logic [TREE_W-1:0] overflow_v2;     // AND terms of the 4-row stage
    } tree_out_t;

endpackage

// ==== tb.f ====
rtl/vpu_pkg.sv
rtl/vpu_decoder.sv
rtl/lane_cla_adder.sv
rtl/approx_compressor_cell.sv
rtl/compressor_tree.sv
rtl/approx_multiplier.sv
rtl/vector_processing_unit.sv
test/tb_vector_processing_unit.sv

// ==== test/tb_vector_processing_unit.sv ====
// VDOT lanes of b hold zero or one set bit so the approximate products stay exact
`timescale 1ns/1ps

module tb_vector_processing_unit
    import vpu_pkg::*;
();

    localparam int CLK_PERIOD        = 100;
    localparam int IDLE_CYCLES       = 5;
    localparam int VECTORS_PER_GROUP = 200;
    localparam int NUM_GROUPS        = 5;
    localparam int SLACK_CYCLES      = 45;  // Drain cycle plus headroom
    localparam int TIMEOUT_NS        =
        2 * (IDLE_CYCLES + NUM_GROUPS * VECTORS_PER_GROUP + SLACK_CYCLES) * CLK_PERIOD;

    // Which rule the current vector follows
    typedef enum logic [2:0] {
        K_ADD,
        K_SUB,
        K_DOT,
        K_CROSS,
        K_OTHER
    } kind_e;

    logic       clk;
    vpu_instr_t instr;
    vec_word_t  operand_a;
    vec_word_t  operand_b;
    vec_word_t  result;
    logic       check_en;
    kind_e      kind;
    vec_word_t  expected;
    integer     seed;

    vector_processing_unit dut0 (
        .instr_i     (instr),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .result_o    (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    function automatic vpu_instr_t build_instr(funct7_t f7, funct3_t f3, opcode_t opc);
        vpu_instr_t w;

        w.funct7 = f7;
        w.funct3 = f3;
        w.opcode = opc;
        return w;
    endfunction

    // Each lane wraps on its own and never carries into the next
    function automatic vec_word_t lanewise_add(vec_word_t a, vec_word_t b);
        vec_word_t r;

        for (int k = 0; k < NUM_LANES; k++)
        begin
            r[k*LANE_W +: LANE_W] = a[k*LANE_W +: LANE_W] + b[k*LANE_W +: LANE_W];
        end
        return r;
    endfunction

    function automatic vec_word_t lanewise_sub(vec_word_t a, vec_word_t b);
        vec_word_t r;

        for (int k = 0; k < NUM_LANES; k++)
        begin
            r[k*LANE_W +: LANE_W] = a[k*LANE_W +: LANE_W] - b[k*LANE_W +: LANE_W];
        end
        return r;
    endfunction

    function automatic vec_word_t exact_dot(vec_word_t a, vec_word_t b);
        vec_word_t sum;

        sum = '0;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            sum = sum + vec_word_t'(a[k*LANE_W +: LANE_W]) * vec_word_t'(b[k*LANE_W +: LANE_W]);
        end
        return sum;
    endfunction

    // Lane b of zero or a single set bit
    task automatic pick_pow2_word(output vec_word_t b);
        int unsigned r;

        for (int k = 0; k < NUM_LANES; k++)
        begin
            r = $unsigned($random(seed)) % (LANE_W + 1);
            b[k*LANE_W +: LANE_W] = (r == LANE_W) ? lane_t'(0) : lane_t'(1) << r;
        end
    endtask

    task automatic apply_vector(input vpu_instr_t i, input vec_word_t a, input vec_word_t b,
                                input kind_e k);
        @(negedge clk);
        instr     = i;
        operand_a = a;
        operand_b = b;
        kind      = k;
        case (k)
            K_SUB:   expected = lanewise_sub(a, b);
            K_DOT:   expected = exact_dot(a, b);
            K_CROSS: expected = a;
            default: expected = lanewise_add(a, b);  // Undecoded words act as add
        endcase
        check_en = 1'b1;
    endtask

    task automatic report_mismatch(input string what);
        $display("ERROR: time %0t: %s wrong, instr %h a %h b %h got %h expected %h",
                 $time, what, instr, operand_a, operand_b, result, expected);
        $display("TEST FAILED");
        $fatal(1, "Result check failed");
    endtask

    // Inputs settle half a period before this edge
    always @(posedge clk)
    begin
        if (check_en)
        begin
            case (kind)
                K_ADD:
                    assert (result == expected) else report_mismatch("VADD lane sum");
                K_SUB:
                    assert (result == expected) else report_mismatch("VSUB lane difference");
                K_DOT:
                    assert (result == expected) else report_mismatch("VDOT product sum");
                K_CROSS:
                    assert (result == expected) else report_mismatch("VCROSS pass-through");
                default:
                    assert (result == expected) else report_mismatch("Fallback add");
            endcase
        end
    end

    initial
    begin
        vec_word_t  a_word;
        vec_word_t  b_word;
        logic [31:0] rnd;
        opcode_t    opc;
        funct7_t    f7;

        seed      = 95936;
        instr     = '0;
        operand_a = '0;
        operand_b = '0;
        check_en  = 1'b0;
        kind      = K_ADD;
        expected  = '0;

        repeat (IDLE_CYCLES) @(posedge clk);

        for (int n = 0; n < VECTORS_PER_GROUP; n++)
        begin
            a_word = $random(seed);
            b_word = $random(seed);
            apply_vector(build_instr(F7_VECTOR, F3_VADD, OPC_OP_V), a_word, b_word, K_ADD);
        end

        for (int n = 0; n < VECTORS_PER_GROUP; n++)
        begin
            a_word = $random(seed);
            b_word = $random(seed);
            apply_vector(build_instr(F7_VECTOR, F3_VSUB, OPC_OP_V), a_word, b_word, K_SUB);
        end

        // Largest lane product first
        apply_vector(build_instr(F7_VECTOR, F3_VDOT, OPC_OP_V), 32'hFFFF_FFFF, 32'h8080_8080,
                     K_DOT);
        for (int n = 1; n < VECTORS_PER_GROUP; n++)
        begin
            a_word = $random(seed);
            pick_pow2_word(b_word);
            apply_vector(build_instr(F7_VECTOR, F3_VDOT, OPC_OP_V), a_word, b_word, K_DOT);
        end

        for (int n = 0; n < VECTORS_PER_GROUP; n++)
        begin
            a_word = $random(seed);
            b_word = $random(seed);
            apply_vector(build_instr(F7_VECTOR, F3_VCROSS, OPC_OP_V), a_word, b_word, K_CROSS);
        end

        // Wrong opcode, wrong funct7 and VSMUL in turn
        for (int n = 0; n < VECTORS_PER_GROUP; n++)
        begin
            a_word = $random(seed);
            b_word = $random(seed);
            rnd    = $random(seed);
            opc    = rnd[6:0];
            f7     = rnd[13:7];
            if (opc == OPC_OP_V)
            begin
                opc[0] = ~opc[0];
            end
            if (f7 == F7_VECTOR)
            begin
                f7[0] = ~f7[0];
            end
            case (n % 3)
                0:       apply_vector(build_instr(F7_VECTOR, rnd[16:14], opc), a_word, b_word,
                                      K_OTHER);
                1:       apply_vector(build_instr(f7, rnd[16:14], OPC_OP_V), a_word, b_word,
                                      K_OTHER);
                default: apply_vector(build_instr(F7_VECTOR, F3_VSMUL, OPC_OP_V), a_word, b_word,
                                      K_OTHER);
            endcase
        end

        @(negedge clk);  // Last vector checked on the edge before
        check_en = 1'b0;
        $display("TEST OK");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Simulation timed out before all vectors were applied");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
